// File: Bender.yml
package:
  name: img_controller

sources:
  # Packages first, then the pipeline stages and the top level
  - files:
      - src/img_pkg.sv
      - src/buf_pkg.sv
      - src/pixel_capture.sv
      - src/word_fifo.sv
      - src/frame_buffer.sv
      - src/img_controller.sv

  - target: test
    files:
      - tests/img_controller_assertions.sv
      - tests/img_controller_tb.sv

// File: src/buf_pkg.sv
package buf_pkg;

    // ============================================================
    // Frame buffer RAM
    // ============================================================

    // Pixels are zero-extended into the stored word
    localparam int RAM_WORD_BITS = 16;

    typedef logic [RAM_WORD_BITS-1:0] ram_word_t;

    // One of two blocks
    typedef logic [0:0] ram_block_t;

    // Each block holds one frame of maximum size
    localparam int BLOCK_WORDS = img_pkg::IMG_WIDTH_MAX * img_pkg::IMG_HEIGHT_MAX;
    localparam int RAM_OFFSET_BITS = $clog2(BLOCK_WORDS);

    // Block bit on top, word offset below
    typedef logic [RAM_OFFSET_BITS:0] ram_addr_t;

    // ============================================================
    // Stage FIFOs
    // ============================================================

    localparam int FIFO_DEPTH = 8;

    // Free entries held back for a RAM read already in flight
    localparam int FIFO_SLACK = 2;

endpackage

// File: src/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer import img_pkg::*, buf_pkg::*; (
    input  logic       clk,
    input  logic       fifoIn_rst,
    input  logic       cmd_capture,
    input  ram_block_t cmd_ram_block,
    output logic       capture_start,
    input  logic       capture_done,
    input  width_t     image_width,
    input  height_t    image_height,
    input  logic       in_ready,
    input  pixel_t     in_data,
    output logic       in_trigger,
    input  logic       out_ready,
    output logic       out_trigger,
    output ram_word_t  out_data,
    output logic       status_capture_done
);
    typedef enum logic [1:0] {
        FB_IDLE,
        FB_START,
        FB_CAPTURE,
        FB_READOUT
    } fb_state_t;

    fb_state_t state;

    ram_block_t block_q;
    logic [RAM_OFFSET_BITS-1:0] wr_offset;
    logic [RAM_OFFSET_BITS-1:0] rd_offset;
    logic [RAM_OFFSET_BITS:0] rd_left;
    ram_addr_t wr_addr;
    ram_addr_t rd_addr;

    logic wr_en;
    logic rd_issue;
    logic rd_valid_q;
    ram_word_t ram_q;

    ram_word_t ram [0:2*BLOCK_WORDS-1];

    // ============================================================
    // Datapath
    // ============================================================

    // Words left over from an aborted capture are drained in start
    assign in_trigger = in_ready && ((state == FB_START) || (state == FB_CAPTURE));
    assign wr_en = in_ready && (state == FB_CAPTURE);

    assign wr_addr = {block_q, wr_offset};
    assign rd_addr = {block_q, rd_offset};

    // out_ready leaves room for the read already in flight
    assign rd_issue = (state == FB_READOUT) && (rd_left != '0) && out_ready && !cmd_capture;

    assign out_trigger = rd_valid_q;
    assign out_data = ram_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            ram[wr_addr] <= {{(RAM_WORD_BITS - PIXEL_BITS){1'b0}}, in_data};
        end
        if (rd_issue) begin
            ram_q <= ram[rd_addr];
        end
    end

    // ============================================================
    // Sequencer FSM
    // ============================================================

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state <= FB_IDLE;
            block_q <= '0;
            capture_start <= 1'b0;
            status_capture_done <= 1'b0;
            wr_offset <= '0;
            rd_offset <= '0;
            rd_left <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            capture_start <= 1'b0;
            status_capture_done <= 1'b0;
            rd_valid_q <= rd_issue;

            if (cmd_capture) begin
                // Restart from any state
                block_q <= cmd_ram_block;
                capture_start <= 1'b1;
                wr_offset <= '0;
                rd_left <= '0;
                state <= FB_START;
            end else begin
                case (state)
                    FB_START: begin
                        if (!capture_start && !in_ready) state <= FB_CAPTURE;
                    end
                    FB_CAPTURE: begin
                        if (wr_en) wr_offset <= wr_offset + 1'b1;
                        if (capture_done && !in_ready) begin
                            status_capture_done <= 1'b1;
                            rd_offset <= '0;
                            rd_left <= image_width * image_height;
                            state <= FB_READOUT;
                        end
                    end
                    FB_READOUT: begin
                        if (rd_issue) begin
                            rd_offset <= rd_offset + 1'b1;
                            rd_left <= rd_left - 1'b1;
                        end else if (rd_left == '0) begin
                            state <= FB_IDLE;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: src/img_controller.sv
`timescale 1ns/1ps

module img_controller import img_pkg::*, buf_pkg::*; (
    input  logic        clk,
    input  logic        fifoIn_rst,
    input  logic        cmd_capture,
    input  ram_block_t  cmd_ram_block,
    input  pixel_t      img_d,
    input  logic        img_fv,
    input  logic        img_lv,
    output logic        readout_ready,
    input  logic        readout_trigger,
    output ram_word_t   readout_data,
    output logic        status_capture_done,
    output width_t      status_capture_width,
    output height_t     status_capture_height,
    output stat_count_t status_highlight_count,
    output stat_count_t status_shadow_count
);
    logic capture_start;
    logic capture_done;
    width_t image_width;
    height_t image_height;

    logic pix_ready;
    logic pix_trigger;
    pixel_t pix_data;

    logic in_ready;
    logic in_trigger;
    pixel_t in_data;

    logic out_ready;
    logic out_trigger;
    ram_word_t out_data;

    // Status geometry is the measured frame
    assign status_capture_width = image_width;
    assign status_capture_height = image_height;

    // ============================================================
    // Camera to input FIFO
    // ============================================================

    pixel_capture pixel_capture_inst (
        .clk             (clk),
        .fifoIn_rst      (fifoIn_rst),
        .capture_start   (capture_start),
        .img_d           (img_d),
        .img_fv          (img_fv),
        .img_lv          (img_lv),
        .pix_ready       (pix_ready),
        .pix_trigger     (pix_trigger),
        .pix_data        (pix_data),
        .capture_done    (capture_done),
        .image_width     (image_width),
        .image_height    (image_height),
        .highlight_count (status_highlight_count),
        .shadow_count    (status_shadow_count)
    );

    word_fifo #(.T(pixel_t)) fifo_in (
        .clk           (clk),
        .fifoIn_rst    (fifoIn_rst),
        .write_trigger (pix_trigger),
        .write_data    (pix_data),
        .write_ready   (pix_ready),
        .read_trigger  (in_trigger),
        .read_data     (in_data),
        .read_ready    (in_ready)
    );

    // ============================================================
    // Frame buffer and readout
    // ============================================================

    frame_buffer frame_buffer_inst (
        .clk                 (clk),
        .fifoIn_rst          (fifoIn_rst),
        .cmd_capture         (cmd_capture),
        .cmd_ram_block       (cmd_ram_block),
        .capture_start       (capture_start),
        .capture_done        (capture_done),
        .image_width         (image_width),
        .image_height        (image_height),
        .in_ready            (in_ready),
        .in_data             (in_data),
        .in_trigger          (in_trigger),
        .out_ready           (out_ready),
        .out_trigger         (out_trigger),
        .out_data            (out_data),
        .status_capture_done (status_capture_done)
    );

    word_fifo #(.T(ram_word_t)) fifo_out (
        .clk           (clk),
        .fifoIn_rst    (fifoIn_rst),
        .write_trigger (out_trigger),
        .write_data    (out_data),
        .write_ready   (out_ready),
        .read_trigger  (readout_trigger),
        .read_data     (readout_data),
        .read_ready    (readout_ready)
    );

endmodule

// File: src/img_pkg.sv
package img_pkg;

    // ============================================================
    // Camera pixel
    // ============================================================

    localparam int PIXEL_BITS = 12;

    typedef logic [PIXEL_BITS-1:0] pixel_t;

    // ============================================================
    // Frame geometry
    // ============================================================

    localparam int IMG_WIDTH_MAX = 64;
    localparam int IMG_HEIGHT_MAX = 64;

    // Sized to hold the maximum itself, not just max-1
    typedef logic [$clog2(IMG_WIDTH_MAX+1)-1:0] width_t;
    typedef logic [$clog2(IMG_HEIGHT_MAX+1)-1:0] height_t;

    // ============================================================
    // Highlight and shadow statistics
    // ============================================================

    localparam int STAT_BITS = 18;

    typedef logic [STAT_BITS-1:0] stat_count_t;

    // Top bits all ones is a highlight, all zeros is a shadow
    localparam int STAT_TOP_BITS = 7;

    // Only every 4th column of every 4th row is sampled
    localparam int STAT_STRIDE = 4;

endpackage

// File: src/pixel_capture.sv
`timescale 1ns/1ps

module pixel_capture import img_pkg::*; (
    input  logic        clk,
    input  logic        fifoIn_rst,
    input  logic        capture_start,
    input  pixel_t      img_d,
    input  logic        img_fv,
    input  logic        img_lv,
    input  logic        pix_ready,
    output logic        pix_trigger,
    output pixel_t      pix_data,
    output logic        capture_done,
    output width_t      image_width,
    output height_t     image_height,
    output stat_count_t highlight_count,
    output stat_count_t shadow_count
);
    localparam int STRIDE_BITS = $clog2(STAT_STRIDE);

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_LOW,
        CAP_WAIT_HIGH,
        CAP_ACTIVE
    } cap_state_t;

    cap_state_t state;

    pixel_t img_d_q;
    logic fv_q;
    logic lv_q;
    logic lv_prev;

    logic window;
    logic pix_valid;
    logic line_start;

    logic [STRIDE_BITS-1:0] col;
    logic [STRIDE_BITS-1:0] row;
    logic stat_sample;
    logic [STAT_TOP_BITS-1:0] stat_px;

    // ============================================================
    // Camera input registers
    // ============================================================

    always_ff @(posedge clk) begin
        img_d_q <= img_d;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            fv_q <= 1'b0;
            lv_q <= 1'b0;
            lv_prev <= 1'b0;
        end else begin
            fv_q <= img_fv;
            lv_q <= img_lv;
            lv_prev <= lv_q;
        end
    end

    // Frame start may coincide with the first line
    assign window = (state == CAP_WAIT_HIGH) || (state == CAP_ACTIVE);
    assign pix_valid = window && fv_q && lv_q;
    assign line_start = pix_valid && !lv_prev;

    // Pixel is dropped if the FIFO can't take it
    assign pix_trigger = pix_valid && pix_ready;
    assign pix_data = img_d_q;

    // ============================================================
    // Frame synchronizer
    // ============================================================

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state <= CAP_IDLE;
            capture_done <= 1'b0;
        end else if (capture_start) begin
            // Skip whatever frame is in progress
            state <= CAP_WAIT_LOW;
            capture_done <= 1'b0;
        end else begin
            case (state)
                CAP_WAIT_LOW: begin
                    if (!fv_q) state <= CAP_WAIT_HIGH;
                end
                CAP_WAIT_HIGH: begin
                    if (fv_q) state <= CAP_ACTIVE;
                end
                CAP_ACTIVE: begin
                    if (!fv_q) begin
                        capture_done <= 1'b1;
                        state <= CAP_IDLE;
                    end
                end
                default: ;
            endcase
        end
    end

    // Width of the last line and number of lines
    always_ff @(posedge clk) begin
        if (!fifoIn_rst || capture_start) begin
            image_width <= '0;
            image_height <= '0;
        end else if (line_start) begin
            image_width <= width_t'(1);
            image_height <= image_height + 1'b1;
        end else if (pix_valid) begin
            image_width <= image_width + 1'b1;
        end
    end

    // ============================================================
    // Sampled highlight and shadow counts
    // ============================================================

    // Position within the frame, modulo the stride
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            col <= '0;
            row <= '0;
        end else begin
            col <= lv_q ? col + 1'b1 : '0;
            if (!fv_q) row <= '0;
            else if (lv_prev && !lv_q) row <= row + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        stat_px <= img_d_q[PIXEL_BITS-1 -: STAT_TOP_BITS];
    end

    // Classifier runs one cycle behind the sample decision
    always_ff @(posedge clk) begin
        if (!fifoIn_rst || capture_start) begin
            stat_sample <= 1'b0;
            highlight_count <= '0;
            shadow_count <= '0;
        end else begin
            stat_sample <= pix_valid && (col == '0) && (row == '0);
            if (stat_sample) begin
                if (&stat_px) highlight_count <= highlight_count + 1'b1;
                else if (~|stat_px) shadow_count <= shadow_count + 1'b1;
            end
        end
    end

endmodule

// File: src/word_fifo.sv
`timescale 1ns/1ps

module word_fifo import buf_pkg::*; #(
    parameter type T = ram_word_t
) (
    input  logic clk,
    input  logic fifoIn_rst,
    input  logic write_trigger,
    input  T     write_data,
    output logic write_ready,
    input  logic read_trigger,
    output T     read_data,
    output logic read_ready
);
    localparam int PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    T mem [0:FIFO_DEPTH-1];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic do_write;
    logic do_read;

    // A write past the slack limit still lands while not full
    assign do_write = write_trigger && (count != CNT_BITS'(FIFO_DEPTH));
    assign do_read = read_trigger && read_ready;

    assign write_ready = count <= CNT_BITS'(FIFO_DEPTH - FIFO_SLACK);
    assign read_ready = count != '0;
    assign read_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) mem[wr_ptr] <= write_data;
    end

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: tests/img_controller_assertions.sv
`timescale 1ns/1ps

module img_controller_assertions import buf_pkg::*; (
    input logic      clk,
    input logic      fifoIn_rst,
    input logic      in_trigger,
    input logic      readout_ready,
    input logic      readout_trigger,
    input ram_word_t readout_data,
    input logic      status_capture_done
);
    int assert_failures = 0;
    logic word_captured;

    // Sticky once the frame buffer has taken a pixel word
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) word_captured <= 1'b0;
        else if (in_trigger) word_captured <= 1'b1;
    end

    // ============================================================
    // Readout port rules
    // ============================================================

    readout_after_capture: assert property (
        @(posedge clk) disable iff (!fifoIn_rst)
        $rose(readout_ready) |-> word_captured
    ) else begin
        $error("readout_ready rose before any pixel word was captured");
        assert_failures++;
    end

    done_single_pulse: assert property (
        @(posedge clk) disable iff (!fifoIn_rst)
        status_capture_done |=> !status_capture_done
    ) else begin
        $error("status_capture_done high for two cycles in a row");
        assert_failures++;
    end

    // Head word holds while the receiver stalls
    data_held_on_stall: assert property (
        @(posedge clk) disable iff (!fifoIn_rst)
        readout_ready && !readout_trigger |=> readout_ready && $stable(readout_data)
    ) else begin
        $error("readout_data changed while ready and not triggered");
        assert_failures++;
    end

endmodule

bind img_controller img_controller_assertions img_controller_assertions_inst (
    .clk                 (clk),
    .fifoIn_rst          (fifoIn_rst),
    .in_trigger          (in_trigger),
    .readout_ready       (readout_ready),
    .readout_trigger     (readout_trigger),
    .readout_data        (readout_data),
    .status_capture_done (status_capture_done)
);

// File: tests/img_controller_tb.sv
`timescale 1ns/1ps

module img_controller_tb import img_pkg::*, buf_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY = 10;
    localparam int RST_CYCLES = 16;
    localparam int LINE_BLANK = 6;
    localparam int FRAME_BLANK = 8;
    localparam int NUM_TESTS = 7;
    localparam int MODE_RANDOM = 0;
    localparam int MODE_EXTREME = 1;

    logic clk;
    logic fifoIn_rst;
    logic cmd_capture;
    ram_block_t cmd_ram_block;
    pixel_t img_d;
    logic img_fv;
    logic img_lv;
    logic readout_ready;
    logic readout_trigger;
    ram_word_t readout_data;
    logic status_capture_done;
    width_t status_capture_width;
    height_t status_capture_height;
    stat_count_t status_highlight_count;
    stat_count_t status_shadow_count;

    // Copy of the last frame the camera model played
    pixel_t frame_copy [0:BLOCK_WORDS-1];
    int copy_w = 0;
    int copy_h = 0;

    string cur_test = "reset";
    int exp_count = 0;
    int rd_idx = 0;
    logic stall_en = 1'b0;
    logic stall_now;

    // Status seen at the done pulse
    int done_count = 0;
    width_t done_width;
    height_t done_height;
    stat_count_t done_highlight;
    stat_count_t done_shadow;

    int check_count = 0;
    int mismatch_count = 0;
    int other_errors = 0;

    img_controller img_controller_inst (
        .clk                    (clk),
        .fifoIn_rst             (fifoIn_rst),
        .cmd_capture            (cmd_capture),
        .cmd_ram_block          (cmd_ram_block),
        .img_d                  (img_d),
        .img_fv                 (img_fv),
        .img_lv                 (img_lv),
        .readout_ready          (readout_ready),
        .readout_trigger        (readout_trigger),
        .readout_data           (readout_data),
        .status_capture_done    (status_capture_done),
        .status_capture_width   (status_capture_width),
        .status_capture_height  (status_capture_height),
        .status_highlight_count (status_highlight_count),
        .status_shadow_count    (status_shadow_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // Helpers and compare tasks
    // ============================================================

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("ERROR %s: %s", cur_test, msg);
    endtask

    task automatic check_word(input string what, input ram_word_t exp, input ram_word_t act);
        check_count++;
        if (act !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %04h actual %04h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_width(input string what, input width_t exp, input width_t act);
        check_count++;
        if (act !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_height(input string what, input height_t exp, input height_t act);
        check_count++;
        if (act !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_stat(input string what, input stat_count_t exp, input stat_count_t act);
        check_count++;
        if (act !== exp) begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    function automatic int test_w(input int idx);
        case (idx)
            0: return 16;
            1: return 20;
            2: return 32;
            3: return 24;
            4: return 20;
            5: return 16;
            default: return 12;
        endcase
    endfunction

    function automatic int test_h(input int idx);
        case (idx)
            0: return 8;
            1: return 5;
            2: return 12;
            3: return 10;
            4: return 6;
            5: return 8;
            default: return 9;
        endcase
    endfunction

    function automatic int frame_cycles(input int w, input int h);
        return FRAME_BLANK + 2 + h * (w + LINE_BLANK);
    endfunction

    // Extremes sit on and just past the highlight and shadow limits
    function automatic pixel_t pick_pixel(input int mode);
        if (mode == MODE_RANDOM) return pixel_t'($urandom);
        case ($urandom % 7)
            0: return 12'hFFF;
            1: return 12'hFE0;
            2: return 12'hFDF;
            3: return 12'h000;
            4: return 12'h01F;
            5: return 12'h020;
            default: return pixel_t'($urandom);
        endcase
    endfunction

    // Reference model of the measured geometry and sampled statistics
    function automatic void expected_stats(output width_t ew, output height_t eh,
                                           output stat_count_t hi, output stat_count_t sh);
        logic [STAT_TOP_BITS-1:0] top;
        ew = width_t'(copy_w);
        eh = height_t'(copy_h);
        hi = '0;
        sh = '0;
        for (int r = 0; r < copy_h; r += STAT_STRIDE) begin
            for (int c = 0; c < copy_w; c += STAT_STRIDE) begin
                top = frame_copy[r * copy_w + c][PIXEL_BITS-1 -: STAT_TOP_BITS];
                if (&top) hi++;
                else if (top == '0) sh++;
            end
        end
    endfunction

    // ============================================================
    // Camera model and command
    // ============================================================

    task automatic play_frame(input int w, input int h, input int mode);
        pixel_t px;
        copy_w = w;
        copy_h = h;
        for (int i = 0; i < FRAME_BLANK; i++) begin
            next_cycle();
            img_fv = 1'b0;
            img_lv = 1'b0;
            img_d = pixel_t'($urandom);
        end
        next_cycle();
        img_fv = 1'b1;
        for (int r = 0; r < h; r++) begin
            // Junk data during line blanking
            for (int c = 0; c < w + LINE_BLANK; c++) begin
                next_cycle();
                px = pick_pixel(mode);
                img_lv = (c < w);
                img_d = px;
                if (c < w) frame_copy[r * w + c] = px;
            end
        end
        next_cycle();
        img_fv = 1'b0;
        img_lv = 1'b0;
    endtask

    task automatic send_cmd(input ram_block_t blk);
        next_cycle();
        cmd_capture = 1'b1;
        cmd_ram_block = blk;
        next_cycle();
        cmd_capture = 1'b0;
    endtask

    task automatic run_capture(input int idx, input string name, input int mode,
                               input ram_block_t blk, input logic stall, input logic mid);
        int w;
        int h;
        int done_before;
        int waited;
        width_t ew;
        height_t eh;
        stat_count_t ehi;
        stat_count_t esh;
        w = test_w(idx);
        h = test_h(idx);
        cur_test = name;
        stall_en = stall;
        exp_count = w * h;
        rd_idx = 0;
        done_before = done_count;
        if (mid) begin
            // Command lands in the first line of a decoy frame
            fork
                play_frame(w, h, MODE_RANDOM);
                begin
                    repeat (FRAME_BLANK + 2 + w / 2) @(posedge clk);
                    send_cmd(blk);
                end
            join
        end else begin
            send_cmd(blk);
        end
        play_frame(w, h, mode);
        waited = 0;
        while (done_count == done_before && waited < 2 * frame_cycles(w, h)) begin
            @(negedge clk);
            waited++;
        end
        if (done_count == done_before) begin
            report_failure("no capture done pulse after the frame ended");
        end else begin
            expected_stats(ew, eh, ehi, esh);
            check_width("width", ew, done_width);
            check_height("height", eh, done_height);
            check_stat("highlight count", ehi, done_highlight);
            check_stat("shadow count", esh, done_shadow);
        end
        waited = 0;
        while (rd_idx < exp_count && waited < 4 * exp_count + 40) begin
            @(negedge clk);
            waited++;
        end
        if (rd_idx < exp_count) begin
            report_failure($sformatf("readout stopped after %0d of %0d words", rd_idx, exp_count));
        end
        repeat (20) @(negedge clk);
        if (readout_ready !== 1'b0) report_failure("readout still has data after the frame");
        if (done_count != done_before + 1) report_failure("wrong number of capture done pulses");
    endtask

    // ============================================================
    // Processes
    // ============================================================

    initial begin : done_monitor
        forever begin
            @(negedge clk);
            if (status_capture_done === 1'b1) begin
                done_count++;
                done_width = status_capture_width;
                done_height = status_capture_height;
                done_highlight = status_highlight_count;
                done_shadow = status_shadow_count;
            end
        end
    end

    // Readout consumer, stored word is the pixel zero-extended
    initial begin : readout_compare
        readout_trigger = 1'b0;
        forever begin
            next_cycle();
            stall_now = stall_en && ($urandom % 2 == 1);
            if (readout_ready === 1'b1 && !stall_now) begin
                if (rd_idx < exp_count) begin
                    check_word($sformatf("word %0d", rd_idx), ram_word_t'(frame_copy[rd_idx]),
                               readout_data);
                end else begin
                    report_failure($sformatf("extra readout word %04h past the frame",
                                             readout_data));
                end
                rd_idx++;
                readout_trigger = 1'b1;
            end else begin
                readout_trigger = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = RST_CYCLES + 500;
        for (int i = 0; i < NUM_TESTS; i++) begin
            limit += 4 * frame_cycles(test_w(i), test_h(i)) + 4 * test_w(i) * test_h(i) + 100;
        end
        repeat (limit) @(posedge clk);
        $display("Watchdog timeout: the run did not finish within %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main_flow
        int assert_fails;
        void'($urandom(77));
        fifoIn_rst = 1'b0;
        cmd_capture = 1'b0;
        cmd_ram_block = '0;
        img_d = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        repeat (RST_CYCLES) next_cycle();
        fifoIn_rst = 1'b1;
        next_cycle();

        check_width("width after reset", '0, status_capture_width);
        check_height("height after reset", '0, status_capture_height);
        check_stat("highlight after reset", '0, status_highlight_count);
        check_stat("shadow after reset", '0, status_shadow_count);
        if (readout_ready !== 1'b0 || status_capture_done !== 1'b0) begin
            report_failure("readout_ready or status_capture_done not low after reset");
        end

        run_capture(0, "raster_16x8", MODE_RANDOM, 1'b0, 1'b0, 1'b0);
        run_capture(1, "geometry_20x5", MODE_RANDOM, 1'b1, 1'b0, 1'b0);
        run_capture(2, "stats_extremes", MODE_EXTREME, 1'b0, 1'b0, 1'b0);
        run_capture(3, "backpressure", MODE_RANDOM, 1'b1, 1'b1, 1'b0);
        run_capture(4, "mid_frame_cmd", MODE_RANDOM, 1'b0, 1'b0, 1'b1);
        run_capture(5, "block0_frame_a", MODE_EXTREME, 1'b0, 1'b0, 1'b0);
        run_capture(6, "block1_frame_b", MODE_RANDOM, 1'b1, 1'b1, 1'b0);

        repeat (10) next_cycle();
        assert_fails = img_controller_inst.img_controller_assertions_inst.assert_failures;
        $display("Summary: %0d checks, %0d mismatches, %0d other errors, %0d assertion failures",
                 check_count, mismatch_count, other_errors, assert_fails);
        if (mismatch_count + other_errors + assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/img_pkg.sv
src/buf_pkg.sv
src/pixel_capture.sv
src/word_fifo.sv
src/frame_buffer.sv
src/img_controller.sv
tests/img_controller_assertions.sv
tests/img_controller_tb.sv
